// File: design/kmeans_pkg.sv
package kmeans_pkg;

    localparam int MAX_CLUSTERS = 7;

    typedef logic [8:0]  x_coord_t;
    typedef logic [7:0]  y_coord_t;
    typedef logic [2:0]  cluster_idx_t;
    typedef logic [9:0]  dist_t;    // Max 511 + 255
    typedef logic [23:0] sum_t;     // Also the divider width
    typedef logic [23:0] mass_t;    // Same width as sum_t, used as divisor

    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
    } centroid_t;

    typedef struct packed {
        sum_t  x_sum;
        sum_t  y_sum;
        mass_t mass;
    } cluster_acc_t;

    typedef enum logic [1:0] {
        STORE,
        SCAN,
        DRAIN,
        DIVIDE
    } phase_t;

endpackage

// File: design/mask_ram.sv
`timescale 1ns/1ps

module mask_ram #(
    parameter int WORD_BITS = 64,
    parameter int DEPTH = 900,
    localparam int AW = $clog2(DEPTH)
) (
    input  logic                 clk_in,
    input  logic                 wr_en,
    input  logic [AW-1:0]        wr_addr,
    input  logic [WORD_BITS-1:0] wr_data,
    input  logic [AW-1:0]        rd_addr,
    output logic [WORD_BITS-1:0] rd_data
);

    logic [WORD_BITS-1:0] mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];   // One cycle read latency
    end

endmodule

// File: design/mask_packer.sv
`timescale 1ns/1ps

module mask_packer import kmeans_pkg::*; #(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 180,
    parameter int WORD_BITS = 64,
    localparam int WORDS = FRAME_W / WORD_BITS * FRAME_H,
    localparam int AW = $clog2(WORDS)
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 store_en,
    input  x_coord_t             x_in,
    input  y_coord_t             y_in,
    input  logic                 mask_in,
    output logic                 wr_en,
    output logic [AW-1:0]        wr_addr,
    output logic [WORD_BITS-1:0] wr_data
);

    localparam int LANE_W = $clog2(WORD_BITS);

    logic              in_frame;
    logic [LANE_W-1:0] lane;

    assign in_frame = store_en && (int'(x_in) < FRAME_W) && (int'(y_in) < FRAME_H);
    assign lane     = x_in[LANE_W-1:0];

    // Word goes out the cycle after its last lane
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_frame && (lane == LANE_W'(WORD_BITS - 1));
        end
    end

    always_ff @(posedge clk_in) begin
        if (in_frame) begin
            if (lane == '0) begin
                wr_data <= WORD_BITS'(mask_in);   // Fresh word
            end else begin
                wr_data <= wr_data | (WORD_BITS'(mask_in) << lane);
            end
            wr_addr <= AW'(int'(y_in) * (FRAME_W / WORD_BITS) + int'(x_in) / WORD_BITS);
        end
    end

endmodule

// File: design/cluster_assign.sv
`timescale 1ns/1ps

module cluster_assign import kmeans_pkg::*; #(
    parameter int WORD_BITS = 64
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 word_valid,
    input  logic [WORD_BITS-1:0] word,
    input  x_coord_t             base_x,
    input  y_coord_t             row_y,
    input  centroid_t            centroids [MAX_CLUSTERS],
    input  cluster_idx_t         active_count,
    output logic                 assign_valid,
    output logic [WORD_BITS-1:0] lane_set,
    output cluster_idx_t         lane_idx [WORD_BITS],
    output x_coord_t             out_x,
    output y_coord_t             out_y
);

    cluster_idx_t nearest [WORD_BITS];

    function automatic dist_t manhattan(x_coord_t px, y_coord_t py, centroid_t c);
        x_coord_t dx;
        y_coord_t dy;
        dx = (px > c.x) ? px - c.x : c.x - px;
        dy = (py > c.y) ? py - c.y : c.y - py;
        return dist_t'(dx) + dist_t'(dy);
    endfunction

    // Every lane searches all centroids in parallel
    always_comb begin
        dist_t    best;
        dist_t    d;
        x_coord_t px;
        for (int i = 0; i < WORD_BITS; i++) begin
            px         = base_x + x_coord_t'(i);
            best       = manhattan(px, row_y, centroids[0]);
            nearest[i] = '0;
            for (int k = 1; k < MAX_CLUSTERS; k++) begin
                d = manhattan(px, row_y, centroids[k]);
                // Strict compare keeps the lowest index on a tie
                if (cluster_idx_t'(k) < active_count && d < best) begin
                    best       = d;
                    nearest[i] = cluster_idx_t'(k);
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            assign_valid <= 1'b0;
        end else begin
            assign_valid <= word_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        lane_set <= word;
        lane_idx <= nearest;
        out_x    <= base_x;
        out_y    <= row_y;
    end

endmodule

// File: design/centroid_accum.sv
`timescale 1ns/1ps

module centroid_accum import kmeans_pkg::*; #(
    parameter int WORD_BITS = 64
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 assign_valid,
    input  logic [WORD_BITS-1:0] lane_set,
    input  cluster_idx_t         lane_idx [WORD_BITS],
    input  x_coord_t             in_x,
    input  y_coord_t             in_y,
    input  logic                 acc_clear,
    output cluster_acc_t         acc [MAX_CLUSTERS]
);

    cluster_acc_t word_sum [MAX_CLUSTERS];

    always_comb begin
        cluster_acc_t node [WORD_BITS];
        for (int k = 0; k < MAX_CLUSTERS; k++) begin
            for (int i = 0; i < WORD_BITS; i++) begin
                node[i] = '0;
                if (lane_set[i] && lane_idx[i] == cluster_idx_t'(k)) begin
                    node[i].x_sum = sum_t'(in_x) + sum_t'(i);
                    node[i].y_sum = sum_t'(in_y);
                    node[i].mass  = mass_t'(1);
                end
            end
            // Pairwise tree, result lands in node 0
            for (int s = 1; s < WORD_BITS; s = s * 2) begin
                for (int i = 0; i + s < WORD_BITS; i = i + 2 * s) begin
                    node[i].x_sum = node[i].x_sum + node[i + s].x_sum;
                    node[i].y_sum = node[i].y_sum + node[i + s].y_sum;
                    node[i].mass  = node[i].mass + node[i + s].mass;
                end
            end
            word_sum[k] = node[0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || acc_clear) begin
            for (int k = 0; k < MAX_CLUSTERS; k++) begin
                acc[k] <= '0;
            end
        end else if (assign_valid) begin
            for (int k = 0; k < MAX_CLUSTERS; k++) begin
                acc[k].x_sum <= acc[k].x_sum + word_sum[k].x_sum;
                acc[k].y_sum <= acc[k].y_sum + word_sum[k].y_sum;
                acc[k].mass  <= acc[k].mass + word_sum[k].mass;
            end
        end
    end

endmodule

// File: design/centroid_divider.sv
`timescale 1ns/1ps

module centroid_divider import kmeans_pkg::*; (
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  start,
    input  sum_t  dividend,
    input  mass_t divisor,
    output sum_t  quotient,
    output logic  quot_valid
);

    localparam int W = $bits(sum_t);

    logic [W-1:0]         rem;
    mass_t                div_q;
    logic [W:0]           shifted;
    logic [W:0]           trial;
    logic [$clog2(W)-1:0] step;
    logic                 busy;

    assign shifted = {rem, quotient[W-1]};
    assign trial   = shifted - {1'b0, div_q};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy       <= 1'b0;
            step       <= '0;
            quot_valid <= 1'b0;
        end else begin
            quot_valid <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (int'(step) == W - 1) begin
                    busy       <= 1'b0;
                    quot_valid <= 1'b1;
                end
            end
        end
    end

    // Quotient bits shift in as dividend bits shift out
    always_ff @(posedge clk_in) begin
        if (start) begin
            rem      <= '0;
            quotient <= dividend;
            div_q    <= divisor;
        end else if (busy) begin
            if (!trial[W]) begin
                rem      <= trial[W-1:0];
                quotient <= {quotient[W-2:0], 1'b1};
            end else begin
                rem      <= shifted[W-1:0];   // Restore
                quotient <= {quotient[W-2:0], 1'b0};
            end
        end
    end

endmodule

// File: design/kmeans_sequencer.sv
`timescale 1ns/1ps

module kmeans_sequencer import kmeans_pkg::*; #(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 180,
    parameter int WORD_BITS = 64,
    parameter int MAX_ITER = 10,
    localparam int WORDS = FRAME_W / WORD_BITS * FRAME_H,
    localparam int AW = $clog2(WORDS)
) (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    new_frame,
    input  cluster_idx_t            num_clusters,
    input  centroid_t               centroids_in [MAX_CLUSTERS],
    input  sum_t                    x_quot [MAX_CLUSTERS],
    input  sum_t                    y_quot [MAX_CLUSTERS],
    input  logic [MAX_CLUSTERS-1:0] quot_valid,
    input  mass_t                   mass [MAX_CLUSTERS],
    output logic                    store_en,
    output logic [AW-1:0]           rd_addr,
    output logic                    scan_valid,
    output x_coord_t                scan_x,
    output y_coord_t                scan_y,
    output cluster_idx_t            active_count,
    output centroid_t               centroids [MAX_CLUSTERS],
    output logic                    div_start,
    output logic                    acc_clear,
    output logic                    done
);

    phase_t                          phase;
    logic [1:0]                      drain_cnt;
    logic [$clog2(MAX_ITER+1)-1:0]   iter;

    assign store_en   = (phase == STORE);
    assign scan_valid = (phase == SCAN);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            phase        <= STORE;
            rd_addr      <= '0;
            scan_x       <= '0;
            scan_y       <= '0;
            drain_cnt    <= '0;
            iter         <= '0;
            active_count <= '0;
            div_start    <= 1'b0;
            acc_clear    <= 1'b0;
            done         <= 1'b0;
            for (int k = 0; k < MAX_CLUSTERS; k++) begin
                centroids[k] <= '0;
            end
        end else begin
            div_start <= 1'b0;
            acc_clear <= 1'b0;
            done      <= 1'b0;
            case (phase)
                STORE: begin
                    if (new_frame) begin
                        phase        <= SCAN;
                        active_count <= num_clusters;
                        centroids    <= centroids_in;
                        iter         <= '0;
                        rd_addr      <= '0;
                        scan_x       <= '0;
                        scan_y       <= '0;
                    end
                end
                SCAN: begin
                    rd_addr <= rd_addr + 1'b1;   // One word per cycle
                    if (scan_x == x_coord_t'(FRAME_W - WORD_BITS)) begin
                        scan_x <= '0;
                        scan_y <= scan_y + 1'b1;
                    end else begin
                        scan_x <= scan_x + x_coord_t'(WORD_BITS);
                    end
                    if (rd_addr == AW'(WORDS - 1)) begin
                        phase     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    // Lets the last words leave the pipeline
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == 2'd2) begin
                        phase     <= DIVIDE;
                        div_start <= 1'b1;
                    end
                end
                DIVIDE: begin
                    for (int k = 0; k < MAX_CLUSTERS; k++) begin
                        // Empty or inactive clusters hold their place
                        if (quot_valid[k] && cluster_idx_t'(k) < active_count
                                && mass[k] != '0) begin
                            centroids[k].x <= x_coord_t'(x_quot[k]);
                            centroids[k].y <= y_coord_t'(y_quot[k]);
                        end
                    end
                    if (&quot_valid) begin
                        acc_clear <= 1'b1;
                    end
                    if (acc_clear) begin
                        rd_addr <= '0;
                        scan_x  <= '0;
                        scan_y  <= '0;
                        if (int'(iter) == MAX_ITER - 1) begin
                            phase <= STORE;
                            done  <= 1'b1;
                        end else begin
                            iter  <= iter + 1'b1;
                            phase <= SCAN;
                        end
                    end
                end
                default: phase <= STORE;
            endcase
        end
    end

endmodule

// File: design/kmeans_top.sv
`timescale 1ns/1ps

module kmeans_top import kmeans_pkg::*; #(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 180,
    parameter int WORD_BITS = 64,
    parameter int MAX_ITER = 10
) (
    input  logic         clk_in,
    input  logic         rst_in,
    input  x_coord_t     x_in,
    input  y_coord_t     y_in,
    input  logic         mask_in,
    input  logic         new_frame,
    input  cluster_idx_t num_clusters,
    input  centroid_t    centroids_in [MAX_CLUSTERS],
    output logic         done,
    output centroid_t    centroids_out [MAX_CLUSTERS]
);

    localparam int WORDS = FRAME_W / WORD_BITS * FRAME_H;
    localparam int AW = $clog2(WORDS);

    logic                    store_en;
    logic                    scan_valid;
    logic                    div_start;
    logic                    acc_clear;
    logic                    wr_en;
    logic [AW-1:0]           wr_addr;
    logic [AW-1:0]           rd_addr;
    logic [WORD_BITS-1:0]    wr_data;
    logic [WORD_BITS-1:0]    rd_data;
    x_coord_t                scan_x;
    x_coord_t                word_x;
    x_coord_t                assign_x;
    y_coord_t                scan_y;
    y_coord_t                word_y;
    y_coord_t                assign_y;
    logic                    word_valid;
    logic                    assign_valid;
    cluster_idx_t            active_count;
    logic [WORD_BITS-1:0]    lane_set;
    cluster_idx_t            lane_idx [WORD_BITS];
    cluster_acc_t            acc [MAX_CLUSTERS];
    mass_t                   mass [MAX_CLUSTERS];
    sum_t                    x_quot [MAX_CLUSTERS];
    sum_t                    y_quot [MAX_CLUSTERS];
    logic [MAX_CLUSTERS-1:0] x_valid;
    logic [MAX_CLUSTERS-1:0] y_valid;
    logic [MAX_CLUSTERS-1:0] quot_valid;

    kmeans_sequencer #(
        .FRAME_W(FRAME_W),
        .FRAME_H(FRAME_H),
        .WORD_BITS(WORD_BITS),
        .MAX_ITER(MAX_ITER)
    ) i_sequencer (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .new_frame(new_frame),
        .num_clusters(num_clusters),
        .centroids_in(centroids_in),
        .x_quot(x_quot),
        .y_quot(y_quot),
        .quot_valid(quot_valid),
        .mass(mass),
        .store_en(store_en),
        .rd_addr(rd_addr),
        .scan_valid(scan_valid),
        .scan_x(scan_x),
        .scan_y(scan_y),
        .active_count(active_count),
        .centroids(centroids_out),
        .div_start(div_start),
        .acc_clear(acc_clear),
        .done(done)
    );

    mask_packer #(
        .FRAME_W(FRAME_W),
        .FRAME_H(FRAME_H),
        .WORD_BITS(WORD_BITS)
    ) i_packer (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .store_en(store_en),
        .x_in(x_in),
        .y_in(y_in),
        .mask_in(mask_in),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    mask_ram #(
        .WORD_BITS(WORD_BITS),
        .DEPTH(WORDS)
    ) i_ram (
        .clk_in(clk_in),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    // Match the RAM read latency
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= scan_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        word_x <= scan_x;
        word_y <= scan_y;
    end

    cluster_assign #(
        .WORD_BITS(WORD_BITS)
    ) i_assign (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .word_valid(word_valid),
        .word(rd_data),
        .base_x(word_x),
        .row_y(word_y),
        .centroids(centroids_out),
        .active_count(active_count),
        .assign_valid(assign_valid),
        .lane_set(lane_set),
        .lane_idx(lane_idx),
        .out_x(assign_x),
        .out_y(assign_y)
    );

    centroid_accum #(
        .WORD_BITS(WORD_BITS)
    ) i_accum (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .assign_valid(assign_valid),
        .lane_set(lane_set),
        .lane_idx(lane_idx),
        .in_x(assign_x),
        .in_y(assign_y),
        .acc_clear(acc_clear),
        .acc(acc)
    );

    // x and y share the mass as divisor
    for (genvar k = 0; k < MAX_CLUSTERS; k++) begin : g_div
        assign mass[k]       = acc[k].mass;
        assign quot_valid[k] = x_valid[k] & y_valid[k];

        centroid_divider i_div_x (
            .clk_in(clk_in),
            .rst_in(rst_in),
            .start(div_start),
            .dividend(acc[k].x_sum),
            .divisor(acc[k].mass),
            .quotient(x_quot[k]),
            .quot_valid(x_valid[k])
        );

        centroid_divider i_div_y (
            .clk_in(clk_in),
            .rst_in(rst_in),
            .start(div_start),
            .dividend(acc[k].y_sum),
            .divisor(acc[k].mass),
            .quotient(y_quot[k]),
            .quot_valid(y_valid[k])
        );
    end

endmodule

// File: verif/kmeans_properties.sv
`timescale 1ns/1ps

module kmeans_properties (
    input logic clk_in,
    input logic rst_in,
    input logic store_en,
    input logic scan_valid,
    input logic div_start,
    input logic done
);

    int assert_errors = 0;   // Failed assertions so far

    done_one_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_errors++;
        end

    // Pipeline must be empty before the dividers sample the sums
    div_after_drain: assert property (@(posedge clk_in) disable iff (rst_in)
        div_start |-> !scan_valid && !$past(scan_valid, 1)
                      && !$past(scan_valid, 2) && !$past(scan_valid, 3))
        else begin
            $error("div_start came less than 3 cycles after the scan");
            assert_errors++;
        end

    // A scan always drains and divides before STORE comes back
    scan_not_into_store: assert property (@(posedge clk_in) disable iff (rst_in)
        scan_valid |=> !store_en)
        else begin
            $error("store_en rose right after a scan cycle");
            assert_errors++;
        end

endmodule

bind kmeans_sequencer kmeans_properties i_props (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .store_en(store_en),
    .scan_valid(scan_valid),
    .div_start(div_start),
    .done(done)
);

// File: verif/kmeans_tb.sv
`timescale 1ns/1ps

module kmeans_tb import kmeans_pkg::*; ();

    localparam int FRAME_W = 32;
    localparam int FRAME_H = 8;
    localparam int WORD_BITS = 8;
    localparam int MAX_ITER = 3;
    localparam int WORDS = FRAME_W / WORD_BITS * FRAME_H;
    localparam int RUN_CYCLES = MAX_ITER * (WORDS + 30);   // Scan, drain, divide, clear
    localparam int NUM_RUNS = 7;
    localparam int WATCHDOG_CYCLES = 8 * NUM_RUNS * RUN_CYCLES;

    logic         clk_in;
    logic         rst_in;
    x_coord_t     x_in;
    y_coord_t     y_in;
    logic         mask_in;
    logic         new_frame;
    cluster_idx_t num_clusters;
    centroid_t    centroids_in [MAX_CLUSTERS];
    logic         done;
    centroid_t    centroids_out [MAX_CLUSTERS];

    bit          mask_bits [FRAME_H][FRAME_W];
    centroid_t   init_c [MAX_CLUSTERS];
    int          model_x [MAX_CLUSTERS];
    int          model_y [MAX_CLUSTERS];
    logic [31:0] rng_state = 32'd15;

    kmeans_top #(
        .FRAME_W(FRAME_W),
        .FRAME_H(FRAME_H),
        .WORD_BITS(WORD_BITS),
        .MAX_ITER(MAX_ITER)
    ) i_dut (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .x_in(x_in),
        .y_in(y_in),
        .mask_in(mask_in),
        .new_frame(new_frame),
        .num_clusters(num_clusters),
        .centroids_in(centroids_in),
        .done(done),
        .centroids_out(centroids_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("Timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // Stops the run at the first failed sequencer assertion
    initial begin
        wait (i_dut.i_sequencer.i_props.assert_errors != 0);
        $display("A bound assertion on the sequencer failed");
        $display("** FAIL **");
        $fatal(1, "assertion failure");
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int l1_distance(input int ax, input int ay, input int bx, input int by);
        int dx;
        int dy;
        dx = (ax > bx) ? ax - bx : bx - ax;
        dy = (ay > by) ? ay - by : by - ay;
        return dx + dy;
    endfunction

    task automatic tick();
        @(posedge clk_in);
        #2;   // Outputs settled, inputs change here
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic set_centroid(input int k, input int x, input int y);
        init_c[k].x = x_coord_t'(x);
        init_c[k].y = y_coord_t'(y);
    endtask

    task automatic clear_init();
        for (int k = 0; k < MAX_CLUSTERS; k++) begin
            init_c[k] = '0;
        end
    endtask

    task automatic clear_mask();
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                mask_bits[y][x] = 1'b0;
            end
        end
    endtask

    task automatic add_rect(input int x0, input int y0, input int x1, input int y1);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                mask_bits[y][x] = 1'b1;
            end
        end
    endtask

    task automatic fill_random_mask();
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                rng_state       = xorshift(rng_state);
                mask_bits[y][x] = rng_state[4];
            end
        end
    endtask

    // Raster stream, then idle coordinates outside the frame
    task automatic store_frame();
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                tick();
                x_in    = x_coord_t'(x);
                y_in    = y_coord_t'(y);
                mask_in = mask_bits[y][x];
            end
        end
        tick();
        x_in    = '1;
        y_in    = '1;
        mask_in = 1'b0;
        tick();
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < 2 * RUN_CYCLES) begin
            tick();
            cycles++;
        end
        if (!done) begin
            $display("Clustering did not finish: done never rose within %0d cycles", cycles);
            $display("** FAIL **");
            $fatal(1, "done timeout");
        end
    endtask

    task automatic model_kmeans(input int n);
        int sx [MAX_CLUSTERS];
        int sy [MAX_CLUSTERS];
        int cnt [MAX_CLUSTERS];
        int best;
        int d;
        int bk;
        for (int k = 0; k < MAX_CLUSTERS; k++) begin
            model_x[k] = int'(init_c[k].x);
            model_y[k] = int'(init_c[k].y);
        end
        for (int it = 0; it < MAX_ITER; it++) begin
            for (int k = 0; k < MAX_CLUSTERS; k++) begin
                sx[k]  = 0;
                sy[k]  = 0;
                cnt[k] = 0;
            end
            for (int y = 0; y < FRAME_H; y++) begin
                for (int x = 0; x < FRAME_W; x++) begin
                    if (mask_bits[y][x]) begin
                        bk   = 0;
                        best = l1_distance(x, y, model_x[0], model_y[0]);
                        for (int k = 1; k < n; k++) begin
                            d = l1_distance(x, y, model_x[k], model_y[k]);
                            if (d < best) begin   // Lowest index wins ties
                                best = d;
                                bk   = k;
                            end
                        end
                        sx[bk]  += x;
                        sy[bk]  += y;
                        cnt[bk] += 1;
                    end
                end
            end
            for (int k = 0; k < n; k++) begin
                if (cnt[k] != 0) begin
                    model_x[k] = sx[k] / cnt[k];
                    model_y[k] = sy[k] / cnt[k];
                end
            end
        end
    endtask

    task automatic run_and_compare(input int n);
        tick();
        new_frame    = 1'b1;
        num_clusters = cluster_idx_t'(n);
        centroids_in = init_c;
        tick();
        new_frame = 1'b0;
        wait_done();
        model_kmeans(n);
        for (int k = 0; k < MAX_CLUSTERS; k++) begin
            check($sformatf("centroids_out[%0d].x", k), 32'(centroids_out[k].x), model_x[k]);
            check($sformatf("centroids_out[%0d].y", k), 32'(centroids_out[k].y), model_y[k]);
        end
    endtask

    task automatic check_slot_is_init(input int k);
        check($sformatf("centroids_out[%0d].x", k), 32'(centroids_out[k].x), 32'(init_c[k].x));
        check($sformatf("centroids_out[%0d].y", k), 32'(centroids_out[k].y), 32'(init_c[k].y));
    endtask

    task automatic test_reset();
        for (int c = 0; c < 10; c++) begin
            tick();
            check("done", 32'(done), 0);
            for (int k = 0; k < MAX_CLUSTERS; k++) begin
                check($sformatf("centroids_out[%0d]", k), 32'(centroids_out[k]), 0);
            end
        end
    endtask

    task automatic test_one_cluster();
        int sx;
        int sy;
        int cnt;
        fill_random_mask();
        store_frame();
        clear_init();
        set_centroid(0, 5, 3);
        run_and_compare(1);
        sx  = 0;
        sy  = 0;
        cnt = 0;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                if (mask_bits[y][x]) begin
                    sx  += x;
                    sy  += y;
                    cnt += 1;
                end
            end
        end
        check("centroids_out[0].x mean", 32'(centroids_out[0].x), sx / cnt);
        check("centroids_out[0].y mean", 32'(centroids_out[0].y), sy / cnt);
    endtask

    task automatic test_two_blobs();
        clear_mask();
        add_rect(2, 1, 6, 3);
        add_rect(24, 4, 29, 6);
        store_frame();
        clear_init();
        set_centroid(0, 15, 0);   // Both start between the blobs
        set_centroid(1, 16, 0);
        run_and_compare(2);
    endtask

    task automatic test_empty_cluster();
        clear_mask();
        add_rect(0, 0, 9, 3);
        store_frame();
        clear_init();
        set_centroid(0, 3, 1);
        set_centroid(1, 5, 2);
        set_centroid(2, 31, 7);   // Far corner, gets no pixels
        run_and_compare(3);
        check_slot_is_init(2);
        clear_mask();
        store_frame();
        set_centroid(0, 7, 2);
        set_centroid(1, 20, 5);
        set_centroid(2, 30, 1);
        set_centroid(4, 12, 6);
        run_and_compare(3);
        for (int k = 0; k < MAX_CLUSTERS; k++) begin
            check_slot_is_init(k);
        end
    endtask

    task automatic test_inactive_slots();
        fill_random_mask();
        store_frame();
        clear_init();
        set_centroid(0, 4, 1);
        set_centroid(1, 16, 4);
        set_centroid(2, 28, 6);
        set_centroid(3, 10, 2);   // Decoys sit among the pixels
        set_centroid(4, 20, 3);
        set_centroid(5, 16, 5);
        set_centroid(6, 0, 0);
        run_and_compare(3);
        for (int k = 3; k < MAX_CLUSTERS; k++) begin
            check_slot_is_init(k);
        end
    endtask

    task automatic test_back_to_back();
        fill_random_mask();
        store_frame();
        clear_init();
        set_centroid(0, 8, 2);
        set_centroid(1, 24, 5);
        run_and_compare(2);
        fill_random_mask();
        store_frame();
        run_and_compare(2);   // Model only knows the second mask
    endtask

    initial begin
        rst_in       = 1'b1;
        x_in         = '1;
        y_in         = '1;
        mask_in      = 1'b0;
        new_frame    = 1'b0;
        num_clusters = cluster_idx_t'(1);
        for (int k = 0; k < MAX_CLUSTERS; k++) begin
            centroids_in[k] = '0;
        end
        repeat (2) @(posedge clk_in);
        #2;
        rst_in = 1'b0;

        test_reset();
        test_one_cluster();
        test_two_blobs();
        test_empty_cluster();
        test_inactive_slots();
        test_back_to_back();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: kmeans_top.f
design/kmeans_pkg.sv
design/mask_ram.sv
design/mask_packer.sv
design/cluster_assign.sv
design/centroid_accum.sv
design/centroid_divider.sv
design/kmeans_sequencer.sv
design/kmeans_top.sv
verif/kmeans_properties.sv
verif/kmeans_tb.sv

// File: Bender.yml
package:
  name: kmeans

sources:
  - design/kmeans_pkg.sv
  - design/mask_ram.sv
  - design/mask_packer.sv
  - design/cluster_assign.sv
  - design/centroid_accum.sv
  - design/centroid_divider.sv
  - design/kmeans_sequencer.sv
  - design/kmeans_top.sv
  - target: simulation
    files:
      - verif/kmeans_properties.sv
      - verif/kmeans_tb.sv
